// ==== common/lsu_pkg.sv ====
package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  mask_t;

    localparam int RAM_DEPTH   = 256;
    localparam int RAM_ADDR_W  = $clog2(RAM_DEPTH);
    localparam int LSU_LATENCY = 3;

    // cp0 status and cause field positions
    localparam int CP0_STATUS_IE  = 0;
    localparam int CP0_STATUS_EXL = 1;
    localparam int CP0_IM_LSB     = 8;
    localparam int CP0_IP_LSB     = 8;
    localparam int CP0_INT_W      = 8;

    // primary opcode field in inst[31:26]
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'h00,
        OPC_ADDI    = 6'h08,
        OPC_LB      = 6'h20,
        OPC_LH      = 6'h21,
        OPC_LW      = 6'h23,
        OPC_LBU     = 6'h24,
        OPC_LHU     = 6'h25,
        OPC_SB      = 6'h28,
        OPC_SH      = 6'h29,
        OPC_SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL in inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL     = 6'h00,
        FN_SYSCALL = 6'h0c,
        FN_ADD     = 6'h20
    } funct_e;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_ADDI,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_SYSCALL,
        OP_INVALID
    } oper_e;

    typedef enum logic [3:0] {
        EXC_NO           = 4'h0,
        EXC_INTERRUPT    = 4'h1,
        EXC_INVALID_INST = 4'h2,
        EXC_SYSCALL      = 4'h3,
        EXC_OV           = 4'h4,
        EXC_ADEL         = 4'h5,
        EXC_ADES         = 4'h6
    } excp_e;

    typedef struct packed {
        word_t inst;
        word_t rs_val;
        word_t rt_val;
    } issue_t;

    typedef struct packed {
        oper_e     oper;
        reg_addr_t dest;
        logic      wreg;
        word_t     imm;
        word_t     rs_val;
        word_t     rt_val;
    } decoded_t;

    typedef struct packed {
        oper_e     oper;
        logic      wreg;
        reg_addr_t dest;
        word_t     alu_res;
        word_t     mem_addr;
        word_t     store_src;
        logic      ov;
    } executed_t;

    typedef struct packed {
        logic      wreg;
        reg_addr_t dest;
        word_t     wdata;
        excp_e     excp;
    } result_t;

endpackage

// ==== design/lsu_decode.sv ====
`timescale 1ns/1ns

module lsu_decode
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     issue_valid_i,
    input  issue_t   issue_i,
    output logic     dec_valid_o,
    output decoded_t dec_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rt_field;
    reg_addr_t   rd_field;
    logic [15:0] imm16;
    decoded_t    dec_d;

    assign opcode   = issue_i.inst[31:26];
    assign rt_field = issue_i.inst[20:16];
    assign rd_field = issue_i.inst[15:11];
    assign imm16    = issue_i.inst[15:0];
    assign funct    = issue_i.inst[5:0];

    always_comb begin
        dec_d.oper   = OP_INVALID;
        dec_d.wreg   = 1'b0;
        dec_d.dest   = rt_field;
        dec_d.imm    = {{16{imm16[15]}}, imm16};
        dec_d.rs_val = issue_i.rs_val;
        dec_d.rt_val = issue_i.rt_val;
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    // sll decodes as a nop
                    FN_SLL: dec_d.oper = OP_NOP;
                    FN_SYSCALL: dec_d.oper = OP_SYSCALL;
                    FN_ADD: begin
                        dec_d.oper = OP_ADD;
                        dec_d.wreg = 1'b1;
                        dec_d.dest = rd_field;
                    end
                    default: dec_d.oper = OP_INVALID;
                endcase
            end
            OPC_ADDI: begin
                dec_d.oper = OP_ADDI;
                dec_d.wreg = 1'b1;
            end
            OPC_LB: begin
                dec_d.oper = OP_LB;
                dec_d.wreg = 1'b1;
            end
            OPC_LBU: begin
                dec_d.oper = OP_LBU;
                dec_d.wreg = 1'b1;
            end
            OPC_LH: begin
                dec_d.oper = OP_LH;
                dec_d.wreg = 1'b1;
            end
            OPC_LHU: begin
                dec_d.oper = OP_LHU;
                dec_d.wreg = 1'b1;
            end
            OPC_LW: begin
                dec_d.oper = OP_LW;
                dec_d.wreg = 1'b1;
            end
            OPC_SB: dec_d.oper = OP_SB;
            OPC_SH: dec_d.oper = OP_SH;
            OPC_SW: dec_d.oper = OP_SW;
            default: dec_d.oper = OP_INVALID;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            dec_o <= dec_d;
        end
    end

endmodule

// ==== design/lsu_execute.sv ====
`timescale 1ns/1ns

module lsu_execute
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      dec_valid_i,
    input  decoded_t  dec_i,
    output logic      exe_valid_o,
    output executed_t exe_o
);

    logic      is_arith;
    word_t     op_b;
    word_t     sum;
    executed_t exe_d;

    assign is_arith = (dec_i.oper == OP_ADD) || (dec_i.oper == OP_ADDI);

    // add uses rt, everything else takes the immediate
    assign op_b = (dec_i.oper == OP_ADD) ? dec_i.rt_val : dec_i.imm;
    assign sum  = dec_i.rs_val + op_b;

    always_comb begin
        exe_d.oper      = dec_i.oper;
        exe_d.wreg      = dec_i.wreg;
        exe_d.dest      = dec_i.dest;
        exe_d.alu_res   = sum;
        exe_d.mem_addr  = dec_i.rs_val + dec_i.imm;
        exe_d.store_src = dec_i.rt_val;
        // same operand signs, different result sign
        exe_d.ov        = is_arith && (dec_i.rs_val[31] == op_b[31])
                          && (sum[31] != dec_i.rs_val[31]);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exe_valid_o <= 1'b0;
        end else begin
            exe_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            exe_o <= exe_d;
        end
    end

endmodule

// ==== mem/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,

    input  logic      exe_valid_i,
    input  executed_t exe_i,

    input  word_t     cp0_status_i,
    input  word_t     cp0_cause_i,

    input  word_t     ram_rdata_i,
    output word_t     ram_addr_o,
    output word_t     ram_wdata_o,
    output mask_t     ram_mask_o,
    output logic      ram_we_o,

    output logic      result_valid_o,
    output result_t   result_o
);

    logic [1:0]  lane;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;
    logic        int_pend;
    logic        is_load;
    logic        is_store;
    logic        misalign;
    mask_t       mask;
    word_t       store_data;
    word_t       wdata;
    excp_e       excp;
    result_t     res_d;

    assign lane    = exe_i.mem_addr[1:0];
    assign rd_byte = ram_rdata_i[8*lane +: 8];
    assign rd_half = lane[1] ? ram_rdata_i[31:16] : ram_rdata_i[15:0];

    // interrupt pending on an enabled line while not at exception level
    assign int_pend = (|(cp0_cause_i[CP0_IP_LSB +: CP0_INT_W]
                         & cp0_status_i[CP0_IM_LSB +: CP0_INT_W]))
                      && !cp0_status_i[CP0_STATUS_EXL]
                      && cp0_status_i[CP0_STATUS_IE];

    // lane select, extension and store replication
    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        misalign   = 1'b0;
        mask       = 4'b0000;
        store_data = exe_i.store_src;
        wdata      = exe_i.alu_res;
        case (exe_i.oper)
            OP_LB: begin
                is_load = 1'b1;
                mask    = 4'b0001 << lane;
                wdata   = {{24{rd_byte[7]}}, rd_byte};
            end
            OP_LBU: begin
                is_load = 1'b1;
                mask    = 4'b0001 << lane;
                wdata   = {24'b0, rd_byte};
            end
            OP_LH: begin
                is_load  = 1'b1;
                misalign = lane[0];
                mask     = lane[1] ? 4'b1100 : 4'b0011;
                wdata    = {{16{rd_half[15]}}, rd_half};
            end
            OP_LHU: begin
                is_load  = 1'b1;
                misalign = lane[0];
                mask     = lane[1] ? 4'b1100 : 4'b0011;
                wdata    = {16'b0, rd_half};
            end
            OP_LW: begin
                is_load  = 1'b1;
                misalign = |lane;
                mask     = 4'b1111;
                wdata    = ram_rdata_i;
            end
            OP_SB: begin
                is_store   = 1'b1;
                mask       = 4'b0001 << lane;
                store_data = {4{exe_i.store_src[7:0]}};
            end
            OP_SH: begin
                is_store   = 1'b1;
                misalign   = lane[0];
                mask       = lane[1] ? 4'b1100 : 4'b0011;
                store_data = {2{exe_i.store_src[15:0]}};
            end
            OP_SW: begin
                is_store = 1'b1;
                misalign = |lane;
                mask     = 4'b1111;
            end
            default: begin
            end
        endcase
    end

    // highest priority first
    always_comb begin
        if (int_pend) begin
            excp = EXC_INTERRUPT;
        end else if (exe_i.oper == OP_INVALID) begin
            excp = EXC_INVALID_INST;
        end else if (exe_i.oper == OP_SYSCALL) begin
            excp = EXC_SYSCALL;
        end else if (exe_i.ov) begin
            excp = EXC_OV;
        end else if (is_load && misalign) begin
            excp = EXC_ADEL;
        end else if (is_store && misalign) begin
            excp = EXC_ADES;
        end else begin
            excp = EXC_NO;
        end
    end

    assign ram_addr_o  = exe_i.mem_addr;
    assign ram_wdata_o = store_data;
    assign ram_mask_o  = mask;
    assign ram_we_o    = exe_valid_i && is_store && (excp == EXC_NO);

    always_comb begin
        res_d.wreg  = exe_i.wreg && (excp == EXC_NO);
        res_d.dest  = exe_i.dest;
        res_d.wdata = wdata;
        res_d.excp  = excp;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= exe_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid_i) begin
            result_o <= res_d;
        end
    end

endmodule

// ==== mem/data_ram.sv ====
`timescale 1ns/1ns

module data_ram
    import lsu_pkg::*;
(
    input  logic  clk,
    input  word_t addr_i,
    input  word_t wdata_i,
    input  mask_t mask_i,
    input  logic  we_i,
    output word_t rdata_o
);

    word_t                 mem [RAM_DEPTH];
    logic [RAM_ADDR_W-1:0] idx;

    // upper address bits are dropped so addresses wrap
    assign idx = addr_i[RAM_ADDR_W+1:2];

    assign rdata_o = mem[idx];

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (mask_i[b]) begin
                    mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== design/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top
    import lsu_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  logic    issue_valid_i,
    input  issue_t  issue_i,
    input  word_t   cp0_status_i,
    input  word_t   cp0_cause_i,
    output logic    result_valid_o,
    output result_t result_o
);

    logic      dec_valid;
    decoded_t  dec;
    logic      exe_valid;
    executed_t exe;

    word_t     ram_addr;
    word_t     ram_wdata;
    word_t     ram_rdata;
    mask_t     ram_mask;
    logic      ram_we;

    lsu_decode i_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec)
    );

    lsu_execute i_execute (
        .clk         (clk),
        .reset_i     (reset_i),
        .dec_valid_i (dec_valid),
        .dec_i       (dec),
        .exe_valid_o (exe_valid),
        .exe_o       (exe)
    );

    mem_stage i_mem_stage (
        .clk            (clk),
        .reset_i        (reset_i),
        .exe_valid_i    (exe_valid),
        .exe_i          (exe),
        .cp0_status_i   (cp0_status_i),
        .cp0_cause_i    (cp0_cause_i),
        .ram_rdata_i    (ram_rdata),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata),
        .ram_mask_o     (ram_mask),
        .ram_we_o       (ram_we),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    data_ram i_data_ram (
        .clk     (clk),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .mask_i  (ram_mask),
        .we_i    (ram_we),
        .rdata_o (ram_rdata)
    );

endmodule

// ==== dv/tb_lsu.sv ====
`timescale 1ns/1ns

module tb_lsu
    import lsu_pkg::*;
();

    localparam int FIELDS       = 9;
    localparam int MAX_CASES    = 64;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_TAIL    = 4;
    localparam int MARGIN_NS    = 200;

    typedef struct packed {
        result_t     res;
        logic [31:0] cycle;
    } expect_t;

    logic    clk;
    logic    reset_i;
    logic    issue_valid_i;
    issue_t  issue_i;
    word_t   cp0_status_i;
    word_t   cp0_cause_i;
    logic    result_valid_o;
    result_t result_o;

    logic [31:0] case_mem [MAX_CASES*FIELDS];
    int          num_cases;
    logic        cases_loaded;
    int          seed;
    int          cycle_cnt;
    expect_t     exp_q [$];

    // cp0 words trail the issue by two cycles to meet the memory stage
    word_t status_d1;
    word_t status_d2;
    word_t cause_d1;
    word_t cause_d2;

    lsu_top i_dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .cp0_status_i   (cp0_status_i),
        .cp0_cause_i    (cp0_cause_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("FAIL time=%0t %s got=%h expected=%h",
                                $time, name, got, expected));
        end
    endtask

    task automatic check_result();
        expect_t e;
        if (exp_q.size() == 0) begin
            abort_run($sformatf("time %0t: result strobe with no instruction in flight",
                                $time));
        end else begin
            e = exp_q.pop_front();
            check_value("result_valid_o cycle", 32'(cycle_cnt), e.cycle);
            check_value("result_o.wreg", 32'(result_o.wreg), 32'(e.res.wreg));
            check_value("result_o.excp", 32'(result_o.excp), 32'(e.res.excp));
            // dest and data only mean something with a register write
            if (e.res.wreg) begin
                check_value("result_o.dest", 32'(result_o.dest), 32'(e.res.dest));
                check_value("result_o.wdata", result_o.wdata, e.res.wdata);
            end
        end
    endtask

    task automatic load_cases();
        for (int i = 0; i < MAX_CASES * FIELDS; i++) begin
            case_mem[i] = '1;
        end
        $readmemh("dv/lsu_cases.txt", case_mem);
        num_cases = 0;
        // all ones in the wreg column marks the end of the file
        while (num_cases < MAX_CASES
               && case_mem[num_cases * FIELDS + 5] != 32'hffff_ffff) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            abort_run("case file dv/lsu_cases.txt holds no instructions");
        end else begin
            cases_loaded = 1'b1;
        end
    endtask

    // check the result strobe and then drive the next inputs
    task automatic step_cycle(input logic valid, input int idx);
        int      base;
        expect_t e;
        base = idx * FIELDS;
        @(negedge clk);
        cycle_cnt++;
        if (result_valid_o === 1'b1) begin
            check_result();
        end else if (result_valid_o !== 1'b0) begin
            abort_run($sformatf("time %0t: result_valid_o is unknown", $time));
        end
        cp0_status_i = status_d2;
        cp0_cause_i  = cause_d2;
        status_d2    = status_d1;
        cause_d2     = cause_d1;
        if (valid) begin
            issue_valid_i  = 1'b1;
            issue_i.inst   = case_mem[base];
            issue_i.rs_val = case_mem[base + 1];
            issue_i.rt_val = case_mem[base + 2];
            status_d1      = case_mem[base + 3];
            cause_d1       = case_mem[base + 4];
            e.res.wreg     = case_mem[base + 5][0];
            e.res.dest     = case_mem[base + 6][4:0];
            e.res.wdata    = case_mem[base + 7];
            e.res.excp     = excp_e'(case_mem[base + 8][3:0]);
            e.cycle        = 32'(cycle_cnt + LSU_LATENCY);
            exp_q.push_back(e);
        end else begin
            issue_valid_i = 1'b0;
            issue_i       = '0;
            status_d1     = '0;
            cause_d1      = '0;
        end
    endtask

    initial begin : watchdog
        wait (cases_loaded === 1'b1);
        #((RESET_CYCLES + num_cases * (3 + LSU_LATENCY)) * CLK_PERIOD + MARGIN_NS);
        abort_run("watchdog timeout, the run did not finish in time");
    end

    initial begin : stimulus
        int gap;
        int waited;
        reset_i       = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        cp0_status_i  = '0;
        cp0_cause_i   = '0;
        status_d1     = '0;
        status_d2     = '0;
        cause_d1      = '0;
        cause_d2      = '0;
        cycle_cnt     = 0;
        cases_loaded  = 1'b0;
        seed          = 65;
        load_cases();

        repeat (RESET_CYCLES) step_cycle(1'b0, 0);
        reset_i = 1'b0;

        for (int i = 0; i < num_cases; i++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) step_cycle(1'b0, 0);
            step_cycle(1'b1, i);
        end

        waited = 0;
        while (exp_q.size() != 0 && waited < LSU_LATENCY + IDLE_TAIL) begin
            step_cycle(1'b0, 0);
            waited++;
        end
        // a few idle cycles to catch stray strobes
        repeat (IDLE_TAIL) step_cycle(1'b0, 0);

        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d results never arrived", exp_q.size()));
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// ==== dv/lsu_cases.txt ====
// inst rs rt cp0_status cp0_cause, then expected wreg dest wdata excp
// all hex, one instruction per line
AC220000 00000100 12345678 00000000 00000000 0 00 00000000 0
8C230000 00000100 00000000 00000000 00000000 1 03 12345678 0
8C230000 00000500 00000000 00000000 00000000 1 03 12345678 0
AC220000 00000200 11223344 00000000 00000000 0 00 00000000 0
A0220000 00000200 ABCDEFF0 00000000 00000000 0 00 00000000 0
A0220001 00000200 0000007F 00000000 00000000 0 00 00000000 0
8C230000 00000200 00000000 00000000 00000000 1 03 11227FF0 0
A0220002 00000200 00000085 00000000 00000000 0 00 00000000 0
A0220000 00000203 0000009C 00000000 00000000 0 00 00000000 0
80230000 00000200 00000000 00000000 00000000 1 03 FFFFFFF0 0
90230000 00000200 00000000 00000000 00000000 1 03 000000F0 0
80230001 00000200 00000000 00000000 00000000 1 03 0000007F 0
8023FFFE 00000204 00000000 00000000 00000000 1 03 FFFFFF85 0
90230003 00000200 00000000 00000000 00000000 1 03 0000009C 0
A4220000 00000300 0000BEEF 00000000 00000000 0 00 00000000 0
A4220002 00000300 12347001 00000000 00000000 0 00 00000000 0
84230000 00000300 00000000 00000000 00000000 1 03 FFFFBEEF 0
94230000 00000300 00000000 00000000 00000000 1 03 0000BEEF 0
84230002 00000300 00000000 00000000 00000000 1 03 00007001 0
A4220001 00000300 00005555 00000000 00000000 0 00 00000000 6
94230003 00000300 00000000 00000000 00000000 0 00 00000000 5
8C230002 00000300 00000000 00000000 00000000 0 00 00000000 5
8C230000 00000300 00000000 00000000 00000000 1 03 7001BEEF 0
00222820 00000005 00000007 00000000 00000000 1 05 0000000C 0
00222820 7FFFFFFF 00000001 00000000 00000000 0 00 00000000 4
2026FFFE 00000010 00000000 00000000 00000000 1 06 0000000E 0
2026FFFF 80000000 00000000 00000000 00000000 0 00 00000000 4
0000000C 00000000 00000000 00000000 00000000 0 00 00000000 3
FC000000 00000000 00000000 00000000 00000000 0 00 00000000 2
0000000C 00000000 00000000 00000101 00000100 0 00 00000000 1
FC000000 00000000 00000000 00000101 00000100 0 00 00000000 1
00222820 7FFFFFFF 00000001 00000101 00000100 0 00 00000000 1
AC220000 00000300 11111111 00000101 00000100 0 00 00000000 1
8C230000 00000300 00000000 00000103 00000100 1 03 7001BEEF 0
2026FFFE 00000010 00000000 00000100 00000100 1 06 0000000E 0

// ==== compile.f ====
common/lsu_pkg.sv
design/lsu_decode.sv
design/lsu_execute.sv
mem/mem_stage.sv
mem/data_ram.sv
design/lsu_top.sv
dv/tb_lsu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_lsu
FILELIST  := compile.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the binary exits non-zero on $$fatal, which fails this target
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
